//--- compile.f
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_decoder.sv
verilog/cpu_sequencer.sv
verilog/cpu_datapath.sv
verilog/cpu_top.sv
verification/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu6502_core

sources:
  - verilog/cpu_pkg.sv
  - verilog/cpu_alu.sv
  - verilog/cpu_decoder.sv
  - verilog/cpu_sequencer.sv
  - verilog/cpu_datapath.sv
  - verilog/cpu_top.sv
  - target: test
    files:
      - verification/cpu_tb.sv

//--- verification/cpu_tb.sv
/*
 * Testbench for the 6502-style core.
 * 64 KiB memory model with registered read, directed programs for
 * reset vector, loads/stores, ALU ops, branches, jump and transfers.
 * Each program ends with a store to a marker address.
 */
module cpu_tb;
	localparam logic [15:0] MARKER = 16'h02ff;	// End-of-program store
	localparam logic [7:0] TAKEN = 8'h7a;	// Positive, nonzero
	localparam logic [7:0] NOT_TAKEN = 8'h3c;
	localparam int PROG_BYTES = 700;	// All programs together, roughly
	localparam int TIMEOUT_CYCLES = PROG_BYTES * 4 + 200;

	logic clk;
	logic reset = 1'b1;
	logic [7:0] data_in = 8'h00;
	logic [15:0] addr;
	logic [7:0] data_out;
	logic we;

	logic [7:0] mem [0:65535];
	logic [15:0] rd_addr;	// Registered read address
	logic [15:0] ptr;	// Program load pointer
	logic marker_seen;
	logic [15:0] wr_addr_q[$];	// Observed writes
	logic [7:0] wr_data_q[$];
	logic [15:0] exp_addr_q[$];	// Expected writes
	logic [7:0] exp_data_q[$];
	logic [31:0] rng_state = 32'd71770;
	logic fn, fv, fz, fc;	// Flag model for branch tests
	logic [7:0] res_zp;	// Next branch result slot
	int cycles = 0;

	cpu_top dut (
		.clk      (clk),
		.reset    (reset),
		.data_in  (data_in),
		.addr     (addr),
		.data_out (data_out),
		.we       (we)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the CPU never reached the expected marker write");
			$display("Verification failed");
			$fatal(1, "Simulation timed out");
		end
	end

	// Memory model, write at rising edge, read data valid the cycle after
	always @(posedge clk) begin
		rd_addr <= addr;
		if (reset && cycles > 0)	// Core flops take reset at the first edge
			check(we, 1'b0, "write strobe during reset");
		if (we) begin
			mem[addr] <= data_out;
			if (addr == MARKER) begin
				marker_seen <= 1'b1;
			end else begin
				wr_addr_q.push_back(addr);
				wr_data_q.push_back(data_out);
			end
		end
	end

	always @(negedge clk)
		data_in <= mem[rd_addr];

	task automatic check(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
			$display("Verification failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	function automatic logic [7:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state[7:0];
	endfunction

	task automatic put_byte(input logic [7:0] b);
		mem[ptr] = b;
		ptr = ptr + 16'd1;
	endtask

	task automatic put_pair(input logic [7:0] op, input logic [7:0] operand);
		put_byte(op);
		put_byte(operand);
	endtask

	task automatic put_abs(input logic [7:0] op, input logic [15:0] a);
		put_byte(op);
		put_byte(a[7:0]);	// Little endian
		put_byte(a[15:8]);
	endtask

	task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
	endtask

	// Hold reset, fill memory and point the vector at the program
	task automatic begin_program(input logic [15:0] vector);
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;
		mem[16'hfffc] = vector[7:0];
		mem[16'hfffd] = vector[15:8];
		ptr = vector;
		marker_seen = 1'b0;
		wr_addr_q.delete();
		wr_data_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic end_program();
		put_abs(8'h8d, MARKER);	// STA marker
		put_abs(8'h4c, ptr);	// JMP to itself
	endtask

	task automatic run_program(input string name);
		repeat (2) @(negedge clk);
		reset = 1'b0;
		do
			@(negedge clk);
		while (!marker_seen);
		check(wr_addr_q.size(), exp_addr_q.size(), {name, ": write count"});
		foreach (exp_addr_q[i]) begin
			check(wr_addr_q[i], exp_addr_q[i], {name, ": write address"});
			check(wr_data_q[i], exp_data_q[i], {name, ": write data"});
		end
	endtask

	task automatic reset_vector_run();
		logic [7:0] v;
		v = next_random();
		begin_program(16'h0400);
		put_pair(8'ha9, v);
		put_abs(8'h8d, 16'h0300);
		end_program();
		expect_write(16'h0300, v);
		run_program("reset vector");
	endtask

	task automatic load_store();
		logic [7:0] a, x, y;
		a = next_random();
		x = next_random();
		y = next_random();
		begin_program(16'h0400);
		put_pair(8'ha9, a);	// Immediate loads
		put_pair(8'ha2, x);
		put_pair(8'ha0, y);
		put_pair(8'h85, 8'h10);
		put_pair(8'h86, 8'h11);
		put_pair(8'h84, 8'h12);
		put_abs(8'h8d, 16'h0310);
		put_abs(8'h8e, 16'h0311);
		put_abs(8'h8c, 16'h0312);
		put_pair(8'ha6, 8'h10);	// LDX zp, gets a
		put_abs(8'hac, 16'h0311);	// LDY abs, gets x
		put_abs(8'had, 16'h0312);	// LDA abs, gets y
		put_pair(8'h85, 8'h16);
		put_pair(8'h86, 8'h17);
		put_abs(8'h8c, 16'h0316);
		put_pair(8'ha5, 8'h11);	// LDA zp, gets x
		put_abs(8'hae, 16'h0312);	// LDX abs, gets y
		put_pair(8'ha4, 8'h10);	// LDY zp, gets a
		put_pair(8'h85, 8'h18);
		put_pair(8'h86, 8'h19);
		put_pair(8'h84, 8'h1a);
		end_program();
		expect_write(16'h0010, a);
		expect_write(16'h0011, x);
		expect_write(16'h0012, y);
		expect_write(16'h0310, a);
		expect_write(16'h0311, x);
		expect_write(16'h0312, y);
		expect_write(16'h0016, y);
		expect_write(16'h0017, a);
		expect_write(16'h0316, x);
		expect_write(16'h0018, x);
		expect_write(16'h0019, y);
		expect_write(16'h001a, a);
		run_program("load and store");
	endtask

	// LDA p, then op with q in the mode given by the opcode, then store
	task automatic alu_case(input logic [7:0] op, input logic [7:0] carry_op,
		input logic [7:0] q, input logic [7:0] result, input logic [7:0] dest);
		if (carry_op != 8'h00)
			put_byte(carry_op);	// CLC or SEC
		put_pair(8'ha5, 8'h20);
		case (op[3:2])
			2'b01: put_pair(op, 8'h21);
			2'b10: put_pair(op, q);
			default: put_abs(op, 16'h0021);
		endcase
		put_pair(8'h85, dest);
		expect_write({8'h00, dest}, result);
	endtask

	task automatic arith_logic();
		logic [7:0] p, q;
		p = next_random();
		q = next_random();
		begin_program(16'h0400);
		mem[16'h0020] = p;
		mem[16'h0021] = q;
		alu_case(8'h05, 8'h00, q, p | q, 8'h30);	// ORA zp
		alu_case(8'h29, 8'h00, q, p & q, 8'h31);	// AND imm
		alu_case(8'h4d, 8'h00, q, p ^ q, 8'h32);	// EOR abs
		alu_case(8'h65, 8'h18, q, p + q, 8'h33);	// ADC zp after CLC
		alu_case(8'h69, 8'h38, q, p + q + 8'd1, 8'h34);	// ADC imm after SEC
		alu_case(8'hed, 8'h38, q, p - q, 8'h35);	// SBC abs, no borrow
		alu_case(8'he5, 8'h18, q, p - q - 8'd1, 8'h36);	// SBC zp with borrow
		alu_case(8'h2d, 8'h00, q, p & q, 8'h37);
		alu_case(8'h49, 8'h00, q, p ^ q, 8'h38);
		alu_case(8'h0d, 8'h00, q, p | q, 8'h39);
		end_program();
		run_program("arithmetic and logic");
	endtask

	task automatic adc_setup(input logic [7:0] a, input logic [7:0] b);
		int sum;
		int ssum;
		put_byte(8'h18);
		put_pair(8'ha9, a);
		put_pair(8'h69, b);
		sum = a + b;
		ssum = $signed(a) + $signed(b);
		fc = (sum > 255);
		fv = (ssum > 127) || (ssum < -128);
		fz = (sum[7:0] == 8'h00);
		fn = sum[7];
	endtask

	task automatic cmp_setup(input logic [7:0] a, input logic [7:0] b);
		int diff;
		put_pair(8'ha9, a);
		put_pair(8'hc9, b);
		diff = a - b;
		fc = (a >= b);
		fz = (a == b);
		fn = diff[7];
	endtask

	task automatic load_setup(input logic [7:0] a);
		put_pair(8'ha9, a);
		fn = a[7];
		fz = (a == 8'h00);
	endtask

	// Branch over a not-taken marker load into a taken marker load
	task automatic branch_case(input logic [7:0] op);
		logic flag;
		logic taken;
		logic [15:0] skip_to;
		case (op[7:6])
			2'd0: flag = fn;
			2'd1: flag = fv;
			2'd2: flag = fc;
			default: flag = fz;
		endcase
		taken = (flag == op[5]);
		put_pair(op, 8'h05);
		put_pair(8'ha2, NOT_TAKEN);
		skip_to = ptr + 16'd5;
		put_abs(8'h4c, skip_to);
		put_pair(8'ha2, TAKEN);
		put_pair(8'h86, res_zp);
		expect_write({8'h00, res_zp}, taken ? TAKEN : NOT_TAKEN);
		res_zp = res_zp + 8'd1;
		fn = 1'b0;	// Both marker loads clear N and Z
		fz = 1'b0;
	endtask

	task automatic branch_flags();
		logic [7:0] op;
		begin_program(16'h0400);
		res_zp = 8'h40;
		for (int i = 0; i < 8; i++) begin
			op = {i[2:0], 5'b10000};
			adc_setup(8'h50, 8'h50);	// N V set, Z C clear
			branch_case(op);
			adc_setup(8'hd0, 8'h30);	// N V clear, Z C set
			branch_case(op);
			cmp_setup(next_random(), next_random());
			branch_case(op);
			load_setup(next_random());
			branch_case(op);
		end
		put_abs(8'h4c, 16'h0afa);	// Taken BNE at 0AFC lands on next page
		ptr = 16'h0afa;
		load_setup(8'h01);
		branch_case(8'hd0);
		end_program();
		run_program("branches");
	endtask

	task automatic jump_over();
		logic [7:0] v;
		v = next_random();
		begin_program(16'h0800);
		put_pair(8'ha9, v);
		put_abs(8'h4c, ptr + 16'd6);
		put_abs(8'h8d, 16'h0320);	// Skipped
		put_abs(8'h8d, 16'h0321);
		end_program();
		expect_write(16'h0321, v);
		run_program("jump");
	endtask

	task automatic transfer_count();
		logic [7:0] v;
		v = next_random();
		begin_program(16'h0400);
		put_pair(8'ha9, v);
		put_byte(8'haa);	// TAX
		put_byte(8'he8);	// INX
		put_byte(8'he8);
		put_byte(8'hca);	// DEX
		put_byte(8'h8a);	// TXA
		put_byte(8'ha8);	// TAY
		put_pair(8'h85, 8'h60);
		put_pair(8'h84, 8'h61);
		put_byte(8'hc8);	// INY
		put_byte(8'hc8);
		put_byte(8'h88);	// DEY
		put_byte(8'h98);	// TYA
		put_pair(8'h85, 8'h62);
		put_pair(8'h86, 8'h63);
		end_program();
		expect_write(16'h0060, v + 8'd1);
		expect_write(16'h0061, v + 8'd1);
		expect_write(16'h0062, v + 8'd2);
		expect_write(16'h0063, v + 8'd1);
		run_program("transfers and counting");
	endtask

	initial begin
		reset_vector_run();
		load_store();
		arith_logic();
		branch_flags();
		jump_over();
		transfer_count();
		$display("Verification passed");
		$finish;
	end

endmodule

//--- verilog/cpu_top.sv
/*
 * Top level of the 6502-style core.
 * Connects sequencer, decoder and datapath. Memory reads are
 * synchronous; a write lands at the clock edge while we is high.
 */
module cpu_top (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [cpu_pkg::DATA_W-1:0] data_in,
	output logic [cpu_pkg::ADDR_W-1:0] addr,
	output logic [cpu_pkg::DATA_W-1:0] data_out,
	output logic                       we
);
	cpu_pkg::cpu_state_t        state;
	logic [cpu_pkg::ADDR_W-1:0] pc;
	logic [cpu_pkg::DATA_W-1:0] addr_hold;	// Previous PCH for branches
	cpu_pkg::status_t           status;
	logic [cpu_pkg::DATA_W-1:0] alu_out;
	logic                       alu_co;
	logic                       load_reg;
	logic                       load_only;
	logic                       store;
	logic                       adc_sbc;
	logic                       compare;
	logic                       inc;
	logic                       clc;
	logic                       sec;
	cpu_pkg::alu_op_t           alu_op;
	cpu_pkg::reg_sel_t          src_reg;
	cpu_pkg::reg_sel_t          dst_reg;
	logic [2:0]                 cond_code;

	cpu_sequencer u_sequencer (.*);

	cpu_decoder u_decoder (
		.*,
		.ir (data_in)	// Opcode straight off the bus
	);

	cpu_datapath u_datapath (.*);

endmodule

//--- verilog/cpu_datapath.sv
/*
 * Datapath of the 6502-style core.
 * A, X and Y registers, N/V/Z/C flags, ALU input and carry
 * muxes and the store data path. Results are written back
 * in the DECODE cycle of the following instruction.
 */
module cpu_datapath (
	input  logic                       clk,
	input  logic                       reset,
	input  cpu_pkg::cpu_state_t        state,
	input  logic [cpu_pkg::DATA_W-1:0] data_in,
	input  logic [cpu_pkg::ADDR_W-1:0] pc,
	input  logic [cpu_pkg::DATA_W-1:0] addr_hold,
	input  logic                       load_reg,
	input  logic                       load_only,
	input  logic                       adc_sbc,
	input  logic                       compare,
	input  logic                       inc,
	input  logic                       clc,
	input  logic                       sec,
	input  cpu_pkg::alu_op_t           alu_op,
	input  cpu_pkg::reg_sel_t          src_reg,
	input  cpu_pkg::reg_sel_t          dst_reg,
	output cpu_pkg::status_t           status,
	output logic [cpu_pkg::DATA_W-1:0] alu_out,
	output logic                       alu_co,
	output logic [cpu_pkg::DATA_W-1:0] data_out
);
	logic [cpu_pkg::DATA_W-1:0] regs [0:2];	// A, X, Y
	logic [cpu_pkg::DATA_W-1:0] regfile;	// Source register read
	logic [cpu_pkg::DATA_W-1:0] ai;
	logic [cpu_pkg::DATA_W-1:0] bi;
	logic                       ci;
	cpu_pkg::alu_op_t           op;
	logic                       backwards;	// Branch offset sign
	logic                       alu_v;
	logic                       alu_z;
	logic                       alu_n;

	assign regfile = regs[src_reg];
	assign data_out = regfile;	// Store data

	always_comb begin
		case (state)
			cpu_pkg::REG:   ai = regfile;
			cpu_pkg::FETCH: ai = load_only ? '0 : regfile;	// Loads pass operand
			cpu_pkg::BRA0:  ai = data_in;	// Offset
			cpu_pkg::BRA1:  ai = addr_hold;	// Old PCH
			default:        ai = '0;
		endcase
		case (state)
			cpu_pkg::REG, cpu_pkg::BRA1: bi = '0;
			cpu_pkg::BRA0:               bi = pc[cpu_pkg::DATA_W-1:0];
			default:                     bi = data_in;
		endcase
		case (state)
			cpu_pkg::REG:   ci = inc;	// INX/INY add one, DEX/DEY borrow
			cpu_pkg::FETCH: ci = compare | (~load_only & status.c);
			cpu_pkg::BRA1:  ci = alu_co;	// Carry from PCL sum
			default:        ci = 1'b0;
		endcase
		case (state)
			cpu_pkg::REG, cpu_pkg::FETCH: op = alu_op;
			cpu_pkg::BRA1: op = backwards ? cpu_pkg::OP_SUB : cpu_pkg::OP_ADD;
			default:       op = cpu_pkg::OP_ADD;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == cpu_pkg::DECODE && load_reg)
			regs[dst_reg] <= alu_out;
		if (state == cpu_pkg::BRA0)
			backwards <= data_in[cpu_pkg::DATA_W-1];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			status <= '0;
		end else if (state == cpu_pkg::DECODE) begin
			if (load_reg | compare) begin
				status.z <= alu_z;
				status.n <= alu_n;
			end
			if (adc_sbc | compare)
				status.c <= alu_co;
			else if (sec)
				status.c <= 1'b1;
			else if (clc)
				status.c <= 1'b0;
			if (adc_sbc)
				status.v <= alu_v;
		end
	end

	cpu_alu u_alu (
		.clk    (clk),
		.op     (op),
		.ai     (ai),
		.bi     (bi),
		.ci     (ci),
		.result (alu_out),
		.co     (alu_co),
		.v      (alu_v),
		.z      (alu_z),
		.n      (alu_n)
	);

endmodule

//--- verilog/cpu_sequencer.sv
/*
 * Sequencer of the 6502-style core.
 * Per-cycle state machine, program counter, address mux with
 * the previous-address hold register, write enable and the
 * branch condition test.
 */
module cpu_sequencer (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [cpu_pkg::DATA_W-1:0] data_in,
	input  logic [cpu_pkg::DATA_W-1:0] alu_out,
	input  logic                       alu_co,
	input  cpu_pkg::status_t           status,
	input  logic                       store,
	input  logic [2:0]                 cond_code,
	output cpu_pkg::cpu_state_t        state,
	output logic [cpu_pkg::ADDR_W-1:0] pc,
	output logic [cpu_pkg::DATA_W-1:0] addr_hold,
	output logic [cpu_pkg::ADDR_W-1:0] addr,
	output logic                       we
);
	logic [cpu_pkg::ADDR_W-1:0] pc_base;	// Load value before increment
	logic                       pc_inc;
	logic [cpu_pkg::DATA_W-1:0] addr_lo;	// Previous address low byte
	logic                       backwards;	// Branch offset sign
	logic                       flag;	// Flag picked by cond_code
	logic                       cond_true;

	always_comb begin
		case (state)
			cpu_pkg::RST0: pc_base = cpu_pkg::RESET_VECTOR;
			cpu_pkg::JMP1: pc_base = {data_in, alu_out};	// Also ends the vector fetch
			cpu_pkg::BRA1: pc_base = {addr_hold, alu_out};
			cpu_pkg::BRA2: pc_base = {alu_out, pc[cpu_pkg::DATA_W-1:0]};
			default:       pc_base = pc;
		endcase
		case (state)
			cpu_pkg::RST0, cpu_pkg::DECODE, cpu_pkg::FETCH, cpu_pkg::ABS0,
			cpu_pkg::BRA0, cpu_pkg::BRA2, cpu_pkg::JMP1: pc_inc = 1'b1;
			cpu_pkg::BRA1: pc_inc = ~(alu_co ^ backwards);	// Done if page kept
			default:       pc_inc = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= cpu_pkg::RESET_VECTOR;
		else
			pc <= pc_base + {{(cpu_pkg::ADDR_W-1){1'b0}}, pc_inc};
	end

	// Address bus mux
	always_comb begin
		case (state)
			cpu_pkg::RST0: addr = cpu_pkg::RESET_VECTOR;
			cpu_pkg::ABS1,
			cpu_pkg::JMP1: addr = {data_in, alu_out};	// High byte arrives now
			cpu_pkg::ZP0:  addr = {cpu_pkg::ZERO_PAGE, data_in};
			cpu_pkg::BRA1: addr = {addr_hold, alu_out};
			cpu_pkg::BRA2: addr = {alu_out, addr_lo};
			cpu_pkg::REG:  addr = {addr_hold, addr_lo};	// Refetch, no operand byte
			default:       addr = pc;
		endcase
	end

	always_ff @(posedge clk) begin
		{addr_hold, addr_lo} <= addr;
		if (state == cpu_pkg::BRA0)
			backwards <= data_in[cpu_pkg::DATA_W-1];
	end

	assign we = store && (state == cpu_pkg::ZP0 || state == cpu_pkg::ABS1);

	// Codes 0..7 test N, V, C, Z clear then set
	always_comb begin
		case (cond_code[2:1])
			2'd0:    flag = status.n;
			2'd1:    flag = status.v;
			2'd2:    flag = status.c;
			default: flag = status.z;
		endcase
		cond_true = (flag == cond_code[0]);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= cpu_pkg::RST0;
		end else begin
			case (state)
				cpu_pkg::RST0: state <= cpu_pkg::RST1;
				cpu_pkg::RST1: state <= cpu_pkg::JMP1;	// Vector low byte into ALU
				cpu_pkg::DECODE: begin
					casez (data_in)
						8'h4c:                      state <= cpu_pkg::JMP0;
						8'b???1_0000:               state <= cpu_pkg::BRA0;
						8'b???0_1001, 8'ha0, 8'ha2: state <= cpu_pkg::FETCH;
						8'b???0_01??:               state <= cpu_pkg::ZP0;
						8'b???0_11??:               state <= cpu_pkg::ABS0;
						default:                    state <= cpu_pkg::REG;
					endcase
				end
				cpu_pkg::ZP0:  state <= cpu_pkg::FETCH;
				cpu_pkg::ABS0: state <= cpu_pkg::ABS1;
				cpu_pkg::ABS1: state <= cpu_pkg::FETCH;
				cpu_pkg::BRA0: state <= cond_true ? cpu_pkg::BRA1 : cpu_pkg::DECODE;
				cpu_pkg::BRA1: state <= (alu_co ^ backwards) ? cpu_pkg::BRA2 : cpu_pkg::DECODE;
				cpu_pkg::JMP0: state <= cpu_pkg::JMP1;
				cpu_pkg::FETCH, cpu_pkg::REG,
				cpu_pkg::BRA2, cpu_pkg::JMP1: state <= cpu_pkg::DECODE;
				default: state <= cpu_pkg::RST0;
			endcase
		end
	end

endmodule

//--- verilog/cpu_decoder.sv
/*
 * Instruction decoder of the 6502-style core.
 * Matches the opcode in DECODE and latches the control flops
 * used by the rest of the instruction. Unknown opcodes act as NOPs.
 */
module cpu_decoder (
	input  logic                       clk,
	input  logic                       reset,
	input  cpu_pkg::cpu_state_t        state,
	input  logic [cpu_pkg::DATA_W-1:0] ir,
	output logic                       load_reg,
	output logic                       load_only,
	output logic                       store,
	output logic                       adc_sbc,
	output logic                       compare,
	output logic                       inc,
	output logic                       clc,
	output logic                       sec,
	output cpu_pkg::alu_op_t           alu_op,
	output cpu_pkg::reg_sel_t          src_reg,
	output cpu_pkg::reg_sel_t          dst_reg,
	output logic [2:0]                 cond_code
);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			load_reg <= 1'b0;
			load_only <= 1'b0;
			store <= 1'b0;
			adc_sbc <= 1'b0;
			compare <= 1'b0;
			inc <= 1'b0;
			clc <= 1'b0;
			sec <= 1'b0;
			alu_op <= cpu_pkg::OP_ADD;
			src_reg <= cpu_pkg::SEL_A;
			dst_reg <= cpu_pkg::SEL_A;
			cond_code <= 3'd0;
		end else if (state == cpu_pkg::DECODE) begin
			load_reg <= 1'b0;	// NOP unless matched below
			load_only <= 1'b0;
			store <= 1'b0;
			adc_sbc <= 1'b0;
			compare <= 1'b0;
			inc <= 1'b0;
			clc <= (ir == 8'h18);
			sec <= (ir == 8'h38);
			alu_op <= cpu_pkg::OP_ADD;
			src_reg <= cpu_pkg::SEL_A;
			dst_reg <= cpu_pkg::SEL_A;
			cond_code <= ir[7:5];	// Branch condition field
			casez (ir)
				8'haa, 8'ha8: begin	// TAX, TAY
					load_reg <= 1'b1;
					alu_op <= cpu_pkg::OP_A;
					dst_reg <= ir[1] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
				end
				8'h8a, 8'h98: begin	// TXA, TYA
					load_reg <= 1'b1;
					alu_op <= cpu_pkg::OP_A;
					src_reg <= ir[1] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
				end
				8'he8, 8'hca, 8'hc8, 8'h88: begin	// INX, DEX, INY, DEY
					load_reg <= 1'b1;
					inc <= ir[6] & ~ir[1];	// Set for the increments
					alu_op <= (ir[6] & ~ir[1]) ? cpu_pkg::OP_ADD : cpu_pkg::OP_SUB;
					src_reg <= (ir[1] ^ ir[5]) ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
					dst_reg <= (ir[1] ^ ir[5]) ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
				end
				8'ha2, 8'b1010_?110: begin	// LDX
					load_reg <= 1'b1;
					load_only <= 1'b1;
					dst_reg <= cpu_pkg::SEL_X;
				end
				8'ha0, 8'b1010_?100: begin	// LDY
					load_reg <= 1'b1;
					load_only <= 1'b1;
					dst_reg <= cpu_pkg::SEL_Y;
				end
				8'b1000_?110: begin	// STX
					store <= 1'b1;
					src_reg <= cpu_pkg::SEL_X;
				end
				8'b1000_?100: begin	// STY
					store <= 1'b1;
					src_reg <= cpu_pkg::SEL_Y;
				end
				8'b???0_?101, 8'b???0_1001: begin	// Group one, op in ir[7:5]
					load_reg <= (ir[7:5] != 3'd4) && (ir[7:5] != 3'd6);
					load_only <= (ir[7:5] == 3'd5);
					store <= (ir[7:5] == 3'd4);
					adc_sbc <= (ir[6:5] == 2'b11);
					compare <= (ir[7:5] == 3'd6);
					case (ir[7:5])
						3'd0:    alu_op <= cpu_pkg::OP_OR;
						3'd1:    alu_op <= cpu_pkg::OP_AND;
						3'd2:    alu_op <= cpu_pkg::OP_EOR;
						3'd6,
						3'd7:    alu_op <= cpu_pkg::OP_SUB;	// CMP, SBC
						default: alu_op <= cpu_pkg::OP_ADD;	// ADC, LDA, STA
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

//--- verilog/cpu_alu.sv
/*
 * ALU of the 6502-style core.
 * Logic ops, add with carry and subtract as add of inverted B.
 * Result, carry and overflow are registered every clock;
 * zero and negative follow from the registered result.
 */
module cpu_alu (
	input  logic                       clk,
	input  cpu_pkg::alu_op_t           op,
	input  logic [cpu_pkg::DATA_W-1:0] ai,
	input  logic [cpu_pkg::DATA_W-1:0] bi,
	input  logic                       ci,
	output logic [cpu_pkg::DATA_W-1:0] result,
	output logic                       co,
	output logic                       v,
	output logic                       z,
	output logic                       n
);
	logic [cpu_pkg::DATA_W-1:0] b_eff;	// B after optional invert
	logic [cpu_pkg::DATA_W:0]   sum;	// Carry in top bit
	logic [cpu_pkg::DATA_W-1:0] res_nxt;
	logic                       co_nxt;
	logic                       v_nxt;

	always_comb begin
		b_eff = (op == cpu_pkg::OP_SUB) ? ~bi : bi;
		sum = {1'b0, ai} + {1'b0, b_eff} + {{cpu_pkg::DATA_W{1'b0}}, ci};
		res_nxt = sum[cpu_pkg::DATA_W-1:0];
		co_nxt = sum[cpu_pkg::DATA_W];
		// Signed overflow when both inputs agree in sign and the sum does not
		v_nxt = (ai[cpu_pkg::DATA_W-1] == b_eff[cpu_pkg::DATA_W-1]) &&
			(sum[cpu_pkg::DATA_W-1] != ai[cpu_pkg::DATA_W-1]);
		case (op)
			cpu_pkg::OP_OR:  res_nxt = ai | bi;
			cpu_pkg::OP_AND: res_nxt = ai & bi;
			cpu_pkg::OP_EOR: res_nxt = ai ^ bi;
			cpu_pkg::OP_A:   res_nxt = ai;
			default:         res_nxt = sum[cpu_pkg::DATA_W-1:0];	// Add and subtract
		endcase
	end

	always_ff @(posedge clk) begin
		result <= res_nxt;
		co <= co_nxt;
		v <= v_nxt;
	end

	assign z = (result == '0);	// From registered result
	assign n = result[cpu_pkg::DATA_W-1];

endmodule

//--- verilog/cpu_pkg.sv
/*
 * Common definitions for the 8-bit 6502-style core.
 * Bus widths, reset vector, per-cycle state encoding,
 * ALU operation codes, register selects and status flags.
 */
package cpu_pkg;

	localparam int DATA_W = 8;	// Data bus width
	localparam int ADDR_W = 16;	// Address bus width

	localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'hfffc;	// Vector low byte, high follows
	localparam logic [DATA_W-1:0] ZERO_PAGE = 8'h00;	// High byte of zero-page accesses

	// One state per bus cycle
	typedef enum logic [3:0] {
		RST0,	// Present vector low address
		RST1,	// Present vector high address
		DECODE,	// Opcode on data_in, write back previous result
		FETCH,	// Operand on data_in, run ALU, fetch next opcode
		REG,	// Register-only instruction
		ZP0,	// Zero-page address on data_in
		ABS0,	// Absolute low byte
		ABS1,	// Absolute high byte, access operand
		BRA0,	// Offset on data_in, add to PCL
		BRA1,	// Carry into PCH
		BRA2,	// Page crossed, refetch
		JMP0,	// Jump target low byte
		JMP1	// Jump target high byte
	} cpu_state_t;

	typedef enum logic [3:0] {
		OP_OR  = 4'b1100,
		OP_AND = 4'b1101,
		OP_EOR = 4'b1110,
		OP_ADD = 4'b0011,
		OP_SUB = 4'b0111,	// Add of inverted B
		OP_A   = 4'b1111	// Pass A through
	} alu_op_t;

	typedef enum logic [1:0] {
		SEL_A = 2'd0,
		SEL_X = 2'd1,
		SEL_Y = 2'd2
	} reg_sel_t;

	typedef struct packed {
		logic n;	// Negative
		logic v;	// Overflow
		logic z;	// Zero
		logic c;	// Carry
	} status_t;

endpackage
